// ==== verilog/exu_pkg.sv ====
// data word type, alu/branch/load/operand/execute-control codes, divider op helper
package exu_pkg;

  typedef logic [63:0] word_t;

  typedef logic [4:0] alu_op_t;
  localparam alu_op_t ALU_ADD  = 5'd0;
  localparam alu_op_t ALU_SUB  = 5'd1;
  localparam alu_op_t ALU_SLT  = 5'd2;
  localparam alu_op_t ALU_SLTU = 5'd3;
  localparam alu_op_t ALU_XOR  = 5'd4;
  localparam alu_op_t ALU_AND  = 5'd5;
  localparam alu_op_t ALU_OR   = 5'd6;
  localparam alu_op_t ALU_SLL  = 5'd7;
  localparam alu_op_t ALU_SRL  = 5'd8;
  localparam alu_op_t ALU_SRA  = 5'd9;
  localparam alu_op_t ALU_MUL  = 5'd10;
  localparam alu_op_t ALU_DIV  = 5'd11;
  localparam alu_op_t ALU_DIVU = 5'd12;
  localparam alu_op_t ALU_REM  = 5'd13;
  localparam alu_op_t ALU_REMU = 5'd14;
  localparam alu_op_t ALU_COPY = 5'd15;
  localparam alu_op_t ALU_CSR  = 5'd16;

  typedef logic [2:0] branch_t;
  localparam branch_t BR_NONE = 3'd0;
  localparam branch_t BR_JAL  = 3'd1;
  localparam branch_t BR_JALR = 3'd2;
  localparam branch_t BR_BEQ  = 3'd4;
  localparam branch_t BR_BNE  = 3'd5;
  localparam branch_t BR_BLT  = 3'd6;
  localparam branch_t BR_BGE  = 3'd7;

  typedef logic [2:0] mem_op_t;
  localparam mem_op_t MEM_LB  = 3'd0;
  localparam mem_op_t MEM_LBU = 3'd1;
  localparam mem_op_t MEM_LH  = 3'd2;
  localparam mem_op_t MEM_LHU = 3'd3;
  localparam mem_op_t MEM_LW  = 3'd4;
  localparam mem_op_t MEM_LWA = 3'd5;
  localparam mem_op_t MEM_LD  = 3'd6;

  typedef logic [1:0] src_b_t;
  localparam src_b_t SRC_B_REG  = 2'd0;
  localparam src_b_t SRC_B_IMM  = 2'd1;
  localparam src_b_t SRC_B_FOUR = 2'd2;

  typedef logic [3:0] ex_ctl_t;
  localparam ex_ctl_t EX_EBREAK  = 4'd14;
  localparam ex_ctl_t EX_INVALID = 4'd15;

  function automatic logic is_div_op(alu_op_t op);
    return (op >= ALU_DIV) && (op <= ALU_REMU);
  endfunction

endpackage

// ==== verilog/exu_alu.sv ====
// combinational alu with operand select, word cut, results, branch flags and divider operands
`timescale 1ns/1ns

module exu_alu import exu_pkg::*; (
  input  word_t   i_rs1,
  input  word_t   i_rs2,
  input  word_t   i_imm,
  input  word_t   i_pc,
  input  logic    i_src_a_pc,
  input  src_b_t  i_src_b,
  input  alu_op_t i_alu_op,
  input  logic    i_word_cut,
  input  branch_t i_branch,
  output word_t   o_value,
  output word_t   o_div_a,
  output word_t   o_div_b,
  output logic    o_take_branch,
  output logic    o_branch_reg
);

  word_t      src1;
  word_t      src2;
  word_t      imm;
  word_t      src_a;
  word_t      src_b;
  word_t      sub_res;
  word_t      sra_res;
  word_t      raw;
  logic [5:0] shamt;
  logic       zero;
  logic       lt_s;
  logic       lt_u;
  logic       less;
  logic       div_sext;

  // word forms see zero-extended low halves
  assign src1 = i_word_cut ? {32'b0, i_rs1[31:0]} : i_rs1;
  assign src2 = i_word_cut ? {32'b0, i_rs2[31:0]} : i_rs2;
  assign imm  = i_word_cut ? {32'b0, i_imm[31:0]} : i_imm;

  assign src_a = i_src_a_pc ? i_pc : src1;

  always_comb begin
    case (i_src_b)
      SRC_B_REG:  src_b = src2;
      SRC_B_IMM:  src_b = imm;
      SRC_B_FOUR: src_b = 64'd4;
      default:    src_b = '0;
    endcase
  end

  assign sub_res = src_a - src_b;
  assign zero    = (sub_res == '0);
  assign lt_s    = $signed(src_a) < $signed(src_b);
  assign lt_u    = src_a < src_b;
  assign less    = (i_alu_op == ALU_SLTU) ? lt_u : lt_s;

  assign shamt = i_word_cut ? {1'b0, src_b[4:0]} : src_b[5:0];

  always_comb begin
    if (i_word_cut) begin
      sra_res = $signed({{32{src_a[31]}}, src_a[31:0]}) >>> shamt;
    end else begin
      sra_res = $signed(src_a) >>> shamt;
    end
  end

  // divide ops come back through the divider, so they read zero here
  always_comb begin
    case (i_alu_op)
      ALU_ADD:  raw = src_a + src_b;
      ALU_SUB:  raw = sub_res;
      ALU_SLT:  raw = {63'b0, lt_s};
      ALU_SLTU: raw = {63'b0, lt_u};
      ALU_XOR:  raw = src_a ^ src_b;
      ALU_AND:  raw = src_a & src_b;
      ALU_OR:   raw = src_a | src_b;
      ALU_SLL:  raw = src_a << shamt;
      ALU_SRL:  raw = src_a >> shamt;
      ALU_SRA:  raw = sra_res;
      ALU_MUL:  raw = src_a * src_b;
      ALU_COPY: raw = i_imm;
      ALU_CSR:  raw = src_a;
      default:  raw = '0;
    endcase
  end

  assign o_value = i_word_cut ? {{32{raw[31]}}, raw[31:0]} : raw;

  // signed word divide needs sign-extended operands
  assign div_sext = i_word_cut && ((i_alu_op == ALU_DIV) || (i_alu_op == ALU_REM));
  assign o_div_a  = div_sext ? {{32{src_a[31]}}, src_a[31:0]} : src_a;
  assign o_div_b  = div_sext ? {{32{src_b[31]}}, src_b[31:0]} : src_b;

  always_comb begin
    case (i_branch)
      BR_JAL:  o_take_branch = 1'b1;
      BR_JALR: o_take_branch = 1'b1;
      BR_BEQ:  o_take_branch = zero;
      BR_BNE:  o_take_branch = ~zero;
      BR_BLT:  o_take_branch = less;
      BR_BGE:  o_take_branch = ~less;
      default: o_take_branch = 1'b0;
    endcase
  end

  assign o_branch_reg = (i_branch == BR_JALR);

endmodule

// ==== verilog/exu_divider.sv ====
// iterative restoring divider with sign fix-up and risc-v divide corner rules
`timescale 1ns/1ns

module exu_divider #(
  parameter int DIV_W = 64
) (
  input  logic             i_clk,
  input  logic             i_rst_n,
  input  logic             i_start,
  input  logic             i_signed,
  input  logic             i_rem,
  input  logic [DIV_W-1:0] i_a,
  input  logic [DIV_W-1:0] i_b,
  output logic             o_done,
  output logic [DIV_W-1:0] o_q
);

  localparam int CNT_W = $clog2(DIV_W + 1);

  logic             busy;
  logic [CNT_W-1:0] cnt;
  logic [DIV_W-1:0] quo;
  logic [DIV_W-1:0] rem;
  logic [DIV_W-1:0] dvsr;
  logic             neg_q;
  logic             neg_r;
  logic             b_zero;
  logic             sel_rem;
  logic             a_neg;
  logic             b_neg;
  logic [DIV_W-1:0] a_mag;
  logic [DIV_W-1:0] b_mag;
  logic [DIV_W:0]   shifted;
  logic [DIV_W:0]   diff;

  assign a_neg = i_signed & i_a[DIV_W-1];
  assign b_neg = i_signed & i_b[DIV_W-1];
  assign a_mag = a_neg ? -i_a : i_a;
  assign b_mag = b_neg ? -i_b : i_b;

  // one trial subtract per cycle
  assign shifted = {rem, quo[DIV_W-1]};
  assign diff    = shifted - {1'b0, dvsr};

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      busy   <= 1'b0;
      cnt    <= '0;
      o_done <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (i_start) begin
        busy <= 1'b1;
        cnt  <= CNT_W'(DIV_W);
      end else if (busy) begin
        cnt <= cnt - 1'b1;
        if (cnt == CNT_W'(1)) begin
          busy   <= 1'b0;
          o_done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      quo     <= a_mag;
      rem     <= '0;
      dvsr    <= b_mag;
      neg_q   <= a_neg ^ b_neg;
      neg_r   <= a_neg;
      b_zero  <= (i_b == '0);
      sel_rem <= i_rem;
    end else if (busy) begin
      if (!diff[DIV_W]) begin
        rem <= diff[DIV_W-1:0];
        quo <= {quo[DIV_W-2:0], 1'b1};
      end else begin
        rem <= shifted[DIV_W-1:0];
        quo <= {quo[DIV_W-2:0], 1'b0};
      end
    end
  end

  // remainder takes the dividend sign; a zero divisor leaves it equal to the dividend
  // most negative over minus one falls out of the negation unchanged
  always_comb begin
    if (sel_rem) begin
      o_q = neg_r ? -rem : rem;
    end else if (b_zero) begin
      o_q = '1;
    end else begin
      o_q = neg_q ? -quo : quo;
    end
  end

endmodule

// ==== verilog/exu_result_mux.sv ====
// next pc adder, load data extension and write-back select
`timescale 1ns/1ns

module exu_result_mux import exu_pkg::*; (
  input  word_t   i_pc,
  input  word_t   i_rs1,
  input  word_t   i_rs2,
  input  word_t   i_imm,
  input  word_t   i_rdata,
  input  mem_op_t i_mem_op,
  input  logic    i_mem_to_reg,
  input  logic    i_sel_csr,
  input  logic    i_take_branch,
  input  logic    i_branch_reg,
  input  word_t   i_result,
  output word_t   o_next_pc,
  output word_t   o_bus_w
);

  word_t load_ext;

  assign o_next_pc = (i_branch_reg ? i_rs1 : i_pc) + (i_take_branch ? i_imm : 64'd4);

  always_comb begin
    case (i_mem_op)
      MEM_LB:  load_ext = {{56{i_rdata[7]}}, i_rdata[7:0]};
      MEM_LBU: load_ext = {56'b0, i_rdata[7:0]};
      MEM_LH:  load_ext = {{48{i_rdata[15]}}, i_rdata[15:0]};
      MEM_LHU: load_ext = {48'b0, i_rdata[15:0]};
      MEM_LW:  load_ext = {{32{i_rdata[31]}}, i_rdata[31:0]};
      MEM_LWA: load_ext = {{32{i_rdata[31]}}, i_rdata[31:0]};
      MEM_LD:  load_ext = i_rdata;
      default: load_ext = '0;
    endcase
  end

  // csr writes back the old value held in rs2
  always_comb begin
    if (i_mem_to_reg) begin
      o_bus_w = load_ext;
    end else if (i_sel_csr) begin
      o_bus_w = i_rs2;
    end else begin
      o_bus_w = i_result;
    end
  end

endmodule

// ==== verilog/exu_status.sv ====
// halted and aborted flags and the retired operation counter
`timescale 1ns/1ns

module exu_status import exu_pkg::*; (
  input  logic        i_clk,
  input  logic        i_rst_n,
  input  logic        i_retire,
  input  ex_ctl_t     i_ex_ctl,
  output logic        o_halted,
  output logic        o_aborted,
  output logic [31:0] o_retired
);

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_halted  <= 1'b0;
      o_aborted <= 1'b0;
      o_retired <= '0;
    end else if (i_retire) begin
      o_retired <= o_retired + 32'd1;
      if (i_ex_ctl == EX_EBREAK) begin
        o_halted <= 1'b1;
      end
      // invalid instruction also stops the engine
      if (i_ex_ctl == EX_INVALID) begin
        o_halted  <= 1'b1;
        o_aborted <= 1'b1;
      end
    end
  end

endmodule

// ==== verilog/exu_ctrl.sv ====
// handshake fsm, request capture, alu/divider routing and result hold register
`timescale 1ns/1ns

module exu_ctrl import exu_pkg::*; (
  input  logic    i_clk,
  input  logic    i_rst_n,
  input  logic    i_req,
  input  word_t   i_rs1,
  input  word_t   i_rs2,
  input  word_t   i_imm,
  input  word_t   i_pc,
  input  word_t   i_rdata,
  input  logic    i_src_a_pc,
  input  src_b_t  i_src_b,
  input  alu_op_t i_alu_op,
  input  logic    i_word_cut,
  input  branch_t i_branch,
  input  mem_op_t i_mem_op,
  input  logic    i_mem_to_reg,
  input  logic    i_sel_csr,
  input  ex_ctl_t i_ex_ctl,
  input  logic    i_halted,
  input  logic    i_div_done,
  input  word_t   i_div_q,
  input  word_t   i_alu_value,
  output logic    o_ack,
  output logic    o_rejected,
  output logic    o_retire,
  output logic    o_div_start,
  output logic    o_div_signed,
  output logic    o_div_rem,
  output word_t   o_c_rs1,
  output word_t   o_c_rs2,
  output word_t   o_c_imm,
  output word_t   o_c_pc,
  output word_t   o_c_rdata,
  output logic    o_c_src_a_pc,
  output src_b_t  o_c_src_b,
  output alu_op_t o_c_alu_op,
  output logic    o_c_word_cut,
  output branch_t o_c_branch,
  output mem_op_t o_c_mem_op,
  output logic    o_c_mem_to_reg,
  output logic    o_c_sel_csr,
  output ex_ctl_t o_c_ex_ctl,
  output word_t   o_result
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_COMPUTE,
    ST_DIVIDE,
    ST_ACK,
    ST_RELEASE
  } state_t;

  state_t state;
  logic   accept;
  logic   drop;

  assign accept = (state == ST_IDLE) && i_req;
  assign drop   = accept && i_halted;

  assign o_div_signed = (o_c_alu_op == ALU_DIV) || (o_c_alu_op == ALU_REM);
  assign o_div_rem    = (o_c_alu_op == ALU_REM) || (o_c_alu_op == ALU_REMU);

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state       <= ST_IDLE;
      o_ack       <= 1'b0;
      o_rejected  <= 1'b0;
      o_retire    <= 1'b0;
      o_div_start <= 1'b0;
      o_result    <= '0;
    end else begin
      o_retire    <= 1'b0;
      o_div_start <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (drop) begin
            o_rejected <= 1'b1;
            o_result   <= '0;
            state      <= ST_ACK;
          end else if (accept && is_div_op(i_alu_op)) begin
            o_div_start <= 1'b1;
            state       <= ST_DIVIDE;
          end else if (accept) begin
            state <= ST_COMPUTE;
          end
        end
        ST_COMPUTE: begin
          o_result <= i_alu_value;
          o_retire <= 1'b1;
          state    <= ST_ACK;
        end
        ST_DIVIDE: begin
          if (i_div_done) begin
            // word forms keep the low half, sign-extended
            o_result <= o_c_word_cut ? {{32{i_div_q[31]}}, i_div_q[31:0]} : i_div_q;
            o_retire <= 1'b1;
            o_ack    <= 1'b1;
            state    <= ST_RELEASE;
          end
        end
        ST_ACK: begin
          o_ack <= 1'b1;
          state <= ST_RELEASE;
        end
        ST_RELEASE: begin
          if (!i_req) begin
            o_ack      <= 1'b0;
            o_rejected <= 1'b0;
            state      <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // cleared fields with jal give zero next pc and zero write-back
  always_ff @(posedge i_clk) begin
    if (!i_rst_n || drop) begin
      o_c_rs1        <= '0;
      o_c_rs2        <= '0;
      o_c_imm        <= '0;
      o_c_pc         <= '0;
      o_c_rdata      <= '0;
      o_c_src_a_pc   <= 1'b0;
      o_c_src_b      <= SRC_B_REG;
      o_c_alu_op     <= ALU_ADD;
      o_c_word_cut   <= 1'b0;
      o_c_branch     <= BR_JAL;
      o_c_mem_op     <= MEM_LB;
      o_c_mem_to_reg <= 1'b0;
      o_c_sel_csr    <= 1'b0;
      o_c_ex_ctl     <= '0;
    end else if (accept) begin
      o_c_rs1        <= i_rs1;
      o_c_rs2        <= i_rs2;
      o_c_imm        <= i_imm;
      o_c_pc         <= i_pc;
      o_c_rdata      <= i_rdata;
      o_c_src_a_pc   <= i_src_a_pc;
      o_c_src_b      <= i_src_b;
      o_c_alu_op     <= i_alu_op;
      o_c_word_cut   <= i_word_cut;
      o_c_branch     <= i_branch;
      o_c_mem_op     <= i_mem_op;
      o_c_mem_to_reg <= i_mem_to_reg;
      o_c_sel_csr    <= i_sel_csr;
      o_c_ex_ctl     <= i_ex_ctl;
    end
  end

endmodule

// ==== verilog/exu_top.sv ====
// execute engine top level with controller, alu, divider, result mux and status block
`timescale 1ns/1ns

module exu_top import exu_pkg::*; #(
  parameter int DIV_W = 64
) (
  input  logic        i_clk,
  input  logic        i_rst_n,
  input  logic        i_req,
  input  word_t       i_rs1,
  input  word_t       i_rs2,
  input  word_t       i_imm,
  input  word_t       i_pc,
  input  word_t       i_rdata,
  input  logic        i_src_a_pc,
  input  src_b_t      i_src_b,
  input  alu_op_t     i_alu_op,
  input  logic        i_word_cut,
  input  branch_t     i_branch,
  input  mem_op_t     i_mem_op,
  input  logic        i_mem_to_reg,
  input  logic        i_sel_csr,
  input  ex_ctl_t     i_ex_ctl,
  output logic        o_ack,
  output word_t       o_alu_result,
  output word_t       o_next_pc,
  output word_t       o_bus_w,
  output logic        o_rejected,
  output logic        o_halted,
  output logic        o_aborted,
  output logic [31:0] o_retired
);

  word_t   c_rs1;
  word_t   c_rs2;
  word_t   c_imm;
  word_t   c_pc;
  word_t   c_rdata;
  logic    c_src_a_pc;
  src_b_t  c_src_b;
  alu_op_t c_alu_op;
  logic    c_word_cut;
  branch_t c_branch;
  mem_op_t c_mem_op;
  logic    c_mem_to_reg;
  logic    c_sel_csr;
  ex_ctl_t c_ex_ctl;
  word_t   alu_value;
  word_t   div_a;
  word_t   div_b;
  word_t   div_q;
  logic    div_start;
  logic    div_signed;
  logic    div_rem;
  logic    div_done;
  logic    take_branch;
  logic    branch_reg;
  logic    retire;

  exu_ctrl u_ctrl (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_req          (i_req),
    .i_rs1          (i_rs1),
    .i_rs2          (i_rs2),
    .i_imm          (i_imm),
    .i_pc           (i_pc),
    .i_rdata        (i_rdata),
    .i_src_a_pc     (i_src_a_pc),
    .i_src_b        (i_src_b),
    .i_alu_op       (i_alu_op),
    .i_word_cut     (i_word_cut),
    .i_branch       (i_branch),
    .i_mem_op       (i_mem_op),
    .i_mem_to_reg   (i_mem_to_reg),
    .i_sel_csr      (i_sel_csr),
    .i_ex_ctl       (i_ex_ctl),
    .i_halted       (o_halted),
    .i_div_done     (div_done),
    .i_div_q        (div_q),
    .i_alu_value    (alu_value),
    .o_ack          (o_ack),
    .o_rejected     (o_rejected),
    .o_retire       (retire),
    .o_div_start    (div_start),
    .o_div_signed   (div_signed),
    .o_div_rem      (div_rem),
    .o_c_rs1        (c_rs1),
    .o_c_rs2        (c_rs2),
    .o_c_imm        (c_imm),
    .o_c_pc         (c_pc),
    .o_c_rdata      (c_rdata),
    .o_c_src_a_pc   (c_src_a_pc),
    .o_c_src_b      (c_src_b),
    .o_c_alu_op     (c_alu_op),
    .o_c_word_cut   (c_word_cut),
    .o_c_branch     (c_branch),
    .o_c_mem_op     (c_mem_op),
    .o_c_mem_to_reg (c_mem_to_reg),
    .o_c_sel_csr    (c_sel_csr),
    .o_c_ex_ctl     (c_ex_ctl),
    .o_result       (o_alu_result)
  );

  exu_alu u_alu (
    .i_rs1         (c_rs1),
    .i_rs2         (c_rs2),
    .i_imm         (c_imm),
    .i_pc          (c_pc),
    .i_src_a_pc    (c_src_a_pc),
    .i_src_b       (c_src_b),
    .i_alu_op      (c_alu_op),
    .i_word_cut    (c_word_cut),
    .i_branch      (c_branch),
    .o_value       (alu_value),
    .o_div_a       (div_a),
    .o_div_b       (div_b),
    .o_take_branch (take_branch),
    .o_branch_reg  (branch_reg)
  );

  exu_divider #(
    .DIV_W (DIV_W)
  ) u_divider (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_start  (div_start),
    .i_signed (div_signed),
    .i_rem    (div_rem),
    .i_a      (div_a),
    .i_b      (div_b),
    .o_done   (div_done),
    .o_q      (div_q)
  );

  exu_result_mux u_result_mux (
    .i_pc          (c_pc),
    .i_rs1         (c_rs1),
    .i_rs2         (c_rs2),
    .i_imm         (c_imm),
    .i_rdata       (c_rdata),
    .i_mem_op      (c_mem_op),
    .i_mem_to_reg  (c_mem_to_reg),
    .i_sel_csr     (c_sel_csr),
    .i_take_branch (take_branch),
    .i_branch_reg  (branch_reg),
    .i_result      (o_alu_result),
    .o_next_pc     (o_next_pc),
    .o_bus_w       (o_bus_w)
  );

  exu_status u_status (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_retire  (retire),
    .i_ex_ctl  (c_ex_ctl),
    .o_halted  (o_halted),
    .o_aborted (o_aborted),
    .o_retired (o_retired)
  );

endmodule

// ==== tb/exu_assert.sv ====
// concurrent handshake, reset and result stability assertions for the execute engine
`timescale 1ns/1ns

module exu_assert import exu_pkg::*; (
  input logic  i_clk,
  input logic  i_rst_n,
  input logic  i_req,
  input logic  i_ack,
  input word_t i_alu_result,
  input word_t i_next_pc,
  input word_t i_bus_w
);

  // ack only ever answers a pending request
  assert property (@(posedge i_clk) disable iff (!i_rst_n) $rose(i_ack) |-> $past(i_req))
    else $error("o_ack rose without a request");

  assert property (@(posedge i_clk) disable iff (!i_rst_n) i_ack && i_req |=> i_ack)
    else $error("o_ack dropped while i_req was still high");

  assert property (@(posedge i_clk) !i_rst_n |=> !i_ack)
    else $error("o_ack high in the cycle after reset");

  // results frozen for the whole ack phase
  assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_ack && $past(i_ack) |-> $stable(i_alu_result) && $stable(i_next_pc) && $stable(i_bus_w))
    else $error("results changed while o_ack was high");

endmodule

// ==== tb/tb_exu.sv ====
// execute engine testbench with clock, reset, file-driven vectors, handshake and compare tasks
`timescale 1ns/1ns

module tb_exu import exu_pkg::*; ();

  localparam int CLK_HALF  = 10;
  localparam int DRIVE_DLY = 2;
  localparam int WAIT_MAX  = 200;

  logic        clk;
  logic        rst_n;
  logic        req;
  word_t       rs1;
  word_t       rs2;
  word_t       imm;
  word_t       pc;
  word_t       rdata;
  logic        src_a_pc;
  src_b_t      src_b;
  alu_op_t     alu_op;
  logic        word_cut;
  branch_t     branch;
  mem_op_t     mem_op;
  logic        mem_to_reg;
  logic        sel_csr;
  ex_ctl_t     ex_ctl;
  logic        ack;
  word_t       alu_result;
  word_t       next_pc;
  word_t       bus_w;
  logic        rejected;
  logic        halted;
  logic        aborted;
  logic [31:0] retired;

  int              fd;
  int              n_fields;
  int              seed_val;
  int              errors;
  int              timeouts;
  int              vectors;
  int              executed;
  logic            exp_halted;
  logic            exp_aborted;
  logic            run_ok;
  string           line;
  string           cur_test;
  logic [8*16-1:0] name_buf;
  // op wc apc src_b branch mem_op m2r csr ex_ctl hold rejected
  int              ctl [0:10];
  // rs1 rs2 imm pc rdata, then expected alu_result next_pc bus_w
  word_t           val [0:7];

  exu_top #(
    .DIV_W (64)
  ) u_dut (
    .i_clk        (clk),
    .i_rst_n      (rst_n),
    .i_req        (req),
    .i_rs1        (rs1),
    .i_rs2        (rs2),
    .i_imm        (imm),
    .i_pc         (pc),
    .i_rdata      (rdata),
    .i_src_a_pc   (src_a_pc),
    .i_src_b      (src_b),
    .i_alu_op     (alu_op),
    .i_word_cut   (word_cut),
    .i_branch     (branch),
    .i_mem_op     (mem_op),
    .i_mem_to_reg (mem_to_reg),
    .i_sel_csr    (sel_csr),
    .i_ex_ctl     (ex_ctl),
    .o_ack        (ack),
    .o_alu_result (alu_result),
    .o_next_pc    (next_pc),
    .o_bus_w      (bus_w),
    .o_rejected   (rejected),
    .o_halted     (halted),
    .o_aborted    (aborted),
    .o_retired    (retired)
  );

  bind exu_top exu_assert u_assert (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_req        (i_req),
    .i_ack        (o_ack),
    .i_alu_result (o_alu_result),
    .i_next_pc    (o_next_pc),
    .i_bus_w      (o_bus_w)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  task automatic check_word(input string what, input word_t exp, input word_t act);
    if (exp !== act) begin
      errors++;
      $display("ERROR %0s %0s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      errors++;
      $display("ERROR %0s %0s: expected %b, actual %b", cur_test, what, exp, act);
    end
  endtask

  task automatic check_count(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("ERROR %0s %0s: expected %0d, actual %0d", cur_test, what, exp, act);
    end
  endtask

  // sample just after the drive point of each cycle
  task automatic wait_ack(input logic level, output logic ok);
    int cycles;
    ok = 1'b0;
    cycles = 0;
    while (!ok && cycles < WAIT_MAX) begin
      @(posedge clk);
      #DRIVE_DLY;
      cycles++;
      if (ack === level) begin
        ok = 1'b1;
      end
    end
    if (!ok) begin
      timeouts++;
      $display("timeout in %0s: o_ack did not go %0s within %0d cycles",
               cur_test, level ? "high" : "low", WAIT_MAX);
    end
  endtask

  task automatic run_vector(output logic ok);
    int   gap;
    int   i;
    logic exp_rej;
    exp_rej = (ctl[10] != 0);
    gap = $urandom % 4;
    repeat (gap) begin
      @(posedge clk);
      #DRIVE_DLY;
    end
    alu_op     = alu_op_t'(ctl[0]);
    word_cut   = ctl[1][0];
    src_a_pc   = ctl[2][0];
    src_b      = src_b_t'(ctl[3]);
    branch     = branch_t'(ctl[4]);
    mem_op     = mem_op_t'(ctl[5]);
    mem_to_reg = ctl[6][0];
    sel_csr    = ctl[7][0];
    ex_ctl     = ex_ctl_t'(ctl[8]);
    rs1        = val[0];
    rs2        = val[1];
    imm        = val[2];
    pc         = val[3];
    rdata      = val[4];
    req        = 1'b1;
    wait_ack(1'b1, ok);
    if (ok) begin
      check_flag("rejected", exp_rej, rejected);
      check_word("alu_result", val[5], alu_result);
      check_word("next_pc", val[6], next_pc);
      check_word("bus_w", val[7], bus_w);
      // hold the request a few more cycles as back-pressure
      for (i = 0; i < ctl[9]; i++) begin
        @(posedge clk);
        #DRIVE_DLY;
        check_flag("held ack", 1'b1, ack);
      end
      if (ctl[9] > 0) begin
        check_word("held alu_result", val[5], alu_result);
      end
      req = 1'b0;
      wait_ack(1'b0, ok);
    end
    if (ok) begin
      if (!exp_rej) begin
        executed++;
        if (ctl[8] == EX_EBREAK || ctl[8] == EX_INVALID) begin
          exp_halted = 1'b1;
        end
        if (ctl[8] == EX_INVALID) begin
          exp_aborted = 1'b1;
        end
      end
      check_count("retired", executed, retired);
      check_flag("halted", exp_halted, halted);
      check_flag("aborted", exp_aborted, aborted);
    end
  endtask

  initial begin
    seed_val    = $urandom(86403);
    errors      = 0;
    timeouts    = 0;
    vectors     = 0;
    executed    = 0;
    exp_halted  = 1'b0;
    exp_aborted = 1'b0;
    run_ok      = 1'b1;
    cur_test    = "reset";
    rst_n       = 1'b0;
    req         = 1'b0;
    rs1         = '0;
    rs2         = '0;
    imm         = '0;
    pc          = '0;
    rdata       = '0;
    src_a_pc    = 1'b0;
    src_b       = SRC_B_REG;
    alu_op      = ALU_ADD;
    word_cut    = 1'b0;
    branch      = BR_NONE;
    mem_op      = MEM_LB;
    mem_to_reg  = 1'b0;
    sel_csr     = 1'b0;
    ex_ctl      = '0;
    repeat (5) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    check_flag("ack", 1'b0, ack);
    check_flag("rejected", 1'b0, rejected);
    check_flag("halted", 1'b0, halted);
    check_flag("aborted", 1'b0, aborted);
    check_count("retired", 32'd0, retired);
    check_word("alu_result", '0, alu_result);
    check_word("next_pc", '0, next_pc);
    check_word("bus_w", '0, bus_w);

    fd = $fopen("tb/exu_input.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the vector file tb/exu_input.txt");
    end
    while (fd != 0 && run_ok && $fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      name_buf = '0;
      n_fields = $sscanf(line,
        "%s %d %d %d %d %d %d %d %d %d %d %h %h %h %h %h %d %h %h %h",
        name_buf, ctl[0], ctl[1], ctl[2], ctl[3], ctl[4], ctl[5], ctl[6], ctl[7],
        ctl[8], ctl[9], val[0], val[1], val[2], val[3], val[4], ctl[10],
        val[5], val[6], val[7]);
      if (n_fields != 20) begin
        errors++;
        $display("vector line could not be parsed: %0s", line);
        continue;
      end
      cur_test = string'(name_buf);
      vectors++;
      run_vector(run_ok);
    end
    if (fd != 0) begin
      $fclose(fd);
    end

    $display("vectors %0d, executed %0d, errors %0d, timeouts %0d",
             vectors, executed, errors, timeouts);
    if (errors == 0 && timeouts == 0 && vectors > 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== tb/exu_input.txt ====
# name op word_cut src_a_pc src_b branch mem_op mem_to_reg sel_csr ex_ctl hold (decimal)
# rs1 rs2 imm pc rdata (hex) rejected (decimal) exp alu_result next_pc bus_w (hex)
add 0 0 0 0 0 0 0 0 0 0 5 7 0 1000 0 0 c 1004 c
sub 1 0 0 0 0 0 0 0 0 0 3 5 0 1000 0 0 fffffffffffffffe 1004 fffffffffffffffe
xor 4 0 0 0 0 0 0 0 0 0 ff00 ff0 0 1000 0 0 f0f0 1004 f0f0
sll 7 0 0 0 0 0 0 0 0 0 1 3f 0 1000 0 0 8000000000000000 1004 8000000000000000
sra 9 0 0 0 0 0 0 0 0 0 8000000000000000 4 0 1000 0 0 f800000000000000 1004 f800000000000000
mul 10 0 0 0 0 0 0 0 0 5 fffffffffffffffd 7 0 1000 0 0 ffffffffffffffeb 1004 ffffffffffffffeb
lui 15 0 0 1 0 0 0 0 0 0 0 0 ffffffff80000000 1000 0 0 ffffffff80000000 1004 ffffffff80000000
csr 16 0 0 0 0 0 0 1 0 0 aa 55 0 1000 0 0 aa 1004 55
auipc 0 0 1 1 0 0 0 0 0 0 0 0 2000 1000 0 0 3000 1004 3000
addw 0 1 0 0 0 0 0 0 0 0 7fffffff 1 0 1000 0 0 ffffffff80000000 1004 ffffffff80000000
subw 1 1 0 0 0 0 0 0 0 0 0 1 0 1000 0 0 ffffffffffffffff 1004 ffffffffffffffff
srlw 8 1 0 0 0 0 0 0 0 0 ffffffff80000000 4 0 1000 0 0 8000000 1004 8000000
sraw 9 1 0 0 0 0 0 0 0 0 80000000 4 0 1000 0 0 fffffffff8000000 1004 fffffffff8000000
mulw 10 1 0 0 0 0 0 0 0 0 ffffffff 3 0 1000 0 0 fffffffffffffffd 1004 fffffffffffffffd
div 11 0 0 0 0 0 0 0 0 0 ffffffffffffffec 3 0 1000 0 0 fffffffffffffffa 1004 fffffffffffffffa
rem 13 0 0 0 0 0 0 0 0 0 ffffffffffffffec 3 0 1000 0 0 fffffffffffffffe 1004 fffffffffffffffe
divu 12 0 0 0 0 0 0 0 0 0 ffffffffffffffff 10 0 1000 0 0 fffffffffffffff 1004 fffffffffffffff
remu 14 0 0 0 0 0 0 0 0 0 ffffffffffffffff 10 0 1000 0 0 f 1004 f
div_zero 11 0 0 0 0 0 0 0 0 0 1234 0 0 1000 0 0 ffffffffffffffff 1004 ffffffffffffffff
rem_zero 13 0 0 0 0 0 0 0 0 0 ffffffffffffffec 0 0 1000 0 0 ffffffffffffffec 1004 ffffffffffffffec
div_ovf 11 0 0 0 0 0 0 0 0 0 8000000000000000 ffffffffffffffff 0 1000 0 0 8000000000000000 1004 8000000000000000
rem_ovf 13 0 0 0 0 0 0 0 0 0 8000000000000000 ffffffffffffffff 0 1000 0 0 0 1004 0
divw_ovf 11 1 0 0 0 0 0 0 0 0 80000000 ffffffff 0 1000 0 0 ffffffff80000000 1004 ffffffff80000000
remuw 14 1 0 0 0 0 0 0 0 0 ffffffff00000007 2 0 1000 0 0 1 1004 1
beq_t 1 0 0 0 4 0 0 0 0 0 5 5 40 1000 0 0 0 1040 0
bne_t 1 0 0 0 5 0 0 0 0 0 5 6 40 1000 0 0 ffffffffffffffff 1040 ffffffffffffffff
blt_t 2 0 0 0 6 0 0 0 0 0 ffffffffffffffff 1 40 1000 0 0 1 1040 1
bltu_nt 3 0 0 0 6 0 0 0 0 0 ffffffffffffffff 1 40 1000 0 0 0 1004 0
bge_t 2 0 0 0 7 0 0 0 0 0 1 ffffffffffffffff 40 1000 0 0 0 1040 0
jal 0 0 1 2 1 0 0 0 0 0 0 0 100 1000 0 0 1004 1100 1004
jalr 0 0 1 2 2 0 0 0 0 0 2000 0 10 1000 0 0 1004 2010 1004
lb 0 0 0 1 0 0 1 0 0 0 8 0 10 1000 123456789abcde80 0 18 1004 ffffffffffffff80
lbu 0 0 0 1 0 1 1 0 0 0 8 0 10 1000 123456789abcde80 0 18 1004 80
lh 0 0 0 1 0 2 1 0 0 0 8 0 10 1000 123456789abcde80 0 18 1004 ffffffffffffde80
lhu 0 0 0 1 0 3 1 0 0 0 8 0 10 1000 123456789abcde80 0 18 1004 de80
lw 0 0 0 1 0 4 1 0 0 0 8 0 10 1000 123456789abcde80 0 18 1004 ffffffff9abcde80
lwa 0 0 0 1 0 5 1 0 0 0 8 0 10 1000 123456789abcde80 0 18 1004 ffffffff9abcde80
ld 0 0 0 1 0 6 1 0 0 0 8 0 10 1000 123456789abcde80 0 18 1004 123456789abcde80
ebreak 0 0 0 0 0 0 0 0 14 0 1 2 0 1000 0 0 3 1004 3
rej_add 0 0 0 0 0 0 0 0 0 0 4 4 0 1000 0 1 0 0 0
rej_div 11 0 0 0 0 0 0 0 0 2 9 3 0 1000 0 1 0 0 0

// ==== all.f ====
verilog/exu_pkg.sv
verilog/exu_alu.sv
verilog/exu_divider.sv
verilog/exu_result_mux.sv
verilog/exu_status.sv
verilog/exu_ctrl.sv
verilog/exu_top.sv
tb/exu_assert.sv
tb/tb_exu.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_exu -f all.f -o tb_exu

./obj_dir/tb_exu 2>&1 | tee sim.log

if grep -q "Verification failed" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi
echo "simulation finished without a reported failure"
